/* design/colmix_pkg.sv */
package colmix_pkg;

    // palette address width, also the priority PROM address width
    localparam int pal_aw = 10;

    // width of one layer pixel
    localparam int pxl_w = 8;

    // cpu data bus width
    localparam int cpu_dw = 16;

    // one layer pixel, read either as a raw palette index or as fields
    typedef union packed {
        // raw view, low bits of the palette address
        logic [pxl_w-1:0] idx;
        // field view, used by the priority logic
        struct packed {
            logic       bank;
            logic [2:0] hi;
            logic       mark;
            // colour code within the palette group
            logic [2:0] col;
        } f;
    } layer_pxl_u;

    // all four layers for one pixel
    typedef struct packed {
        layer_pxl_u ba0;
        layer_pxl_u obj;
        layer_pxl_u ba1;
        layer_pxl_u ba2;
    } layer_pxls_t;

    // layer picked by the priority PROM
    typedef enum logic [1:0] {
        sel_ba0 = 2'd0,
        sel_obj = 2'd1,
        sel_ba1 = 2'd2,
        sel_ba2 = 2'd3
    } layer_sel_e;

    // cpu side of the palette, dsn is active low per byte
    typedef struct packed {
        logic [1:0]        cs;
        logic [pal_aw-1:0] addr;
        logic [cpu_dw-1:0] wdata;
        logic [1:0]        dsn;
    } cpu_bus_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // active-low blanking levels
    typedef struct packed {
        logic hbl_n;
        logic vbl_n;
    } sync_t;

endpackage

/* design/prio_addr.sv */
`timescale 1ns/1ps

module prio_addr (
    input  logic                          clk,
    input  logic                          pxl_cen,
    input  logic [2:0]                    prisel,
    input  colmix_pkg::layer_pxls_t       pxls,
    input  logic [3:0]                    gfx_en,
    input  colmix_pkg::layer_sel_e        layer,
    output logic [colmix_pkg::pal_aw-1:0] prio_sel_addr,
    output logic [colmix_pkg::pal_aw-1:0] pal_addr
);

    // transparency flags, one per layer
    logic ba0_clr;
    logic obj_clr;
    logic ba1_clr;
    logic ba2_clr;

    // raw pixel of the winning layer
    colmix_pkg::layer_pxl_u win_pxl;

    // ba0 is see-through on colour zero or when disabled
    assign ba0_clr = (pxls.ba0.f.col == 3'd0) || !gfx_en[0];

    // objects also use the mark bit as part of the colour
    assign obj_clr = ({pxls.obj.f.mark, pxls.obj.f.col} == 4'd0) || !gfx_en[3];

    assign ba1_clr = (pxls.ba1.f.col == 3'd0) || !gfx_en[1];

    // ba2 bank 1 never counts as transparent
    assign ba2_clr = !pxls.ba2.f.bank
                  && ((pxls.ba2.f.col == 3'd0) || !gfx_en[2]);

    // priority address, MSB first, sampled every clk
    always_ff @(posedge clk) begin
        prio_sel_addr <= {
            prisel,
            ba0_clr,
            pxls.obj.f.bank,
            obj_clr,
            pxls.ba1.f.bank,
            pxls.ba1.f.mark,
            ba1_clr,
            ba2_clr
        };
    end

    // pick the pixel of the layer the PROM chose
    always_comb begin
        case (layer)
            colmix_pkg::sel_ba0: win_pxl = pxls.ba0;
            colmix_pkg::sel_obj: win_pxl = pxls.obj;
            colmix_pkg::sel_ba1: win_pxl = pxls.ba1;
            default:             win_pxl = pxls.ba2;
        endcase
    end

    // palette address only moves once per pixel
    // layer number on top, raw index below
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_addr <= {layer, win_pxl.idx};
        end
    end

endmodule

/* design/prio_prom.sv */
`timescale 1ns/1ps

module prio_prom (
    input  logic                          clk,
    input  logic [colmix_pkg::pal_aw-1:0] rd_addr,
    input  logic [colmix_pkg::pal_aw-1:0] wr_addr,
    input  logic [1:0]                    din,
    input  logic                          we,
    output colmix_pkg::layer_sel_e        layer
);

    localparam int depth = 2 ** colmix_pkg::pal_aw;

    // 2-bit layer choice per priority address
    logic [1:0] mem [depth];

    // registered read data
    logic [1:0] q;

    // load port, filled by the loader before video starts
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

    // one clk read latency
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

    assign layer = colmix_pkg::layer_sel_e'(q);

endmodule

/* design/pal_ram.sv */
`timescale 1ns/1ps

module pal_ram #(
    parameter int dw = 16
) (
    input  logic                          clk,
    // cpu port, byte writes and registered read
    input  logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    input  logic [dw-1:0]                 cpu_wdata,
    input  logic [dw/8-1:0]               cpu_we,
    output logic [dw-1:0]                 cpu_q,
    // video port, read only
    input  logic [colmix_pkg::pal_aw-1:0] vid_addr,
    output logic [dw-1:0]                 vid_q
);

    localparam int depth = 2 ** colmix_pkg::pal_aw;

    // number of byte lanes
    localparam int nb = dw / 8;

    logic [dw-1:0] mem [depth];

    // cpu side
    // each lane written on its own enable
    // read returns the word as it was before this write
    always_ff @(posedge clk) begin
        for (int b = 0; b < nb; b++) begin
            if (cpu_we[b]) begin
                mem[cpu_addr][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
            end
        end
        cpu_q <= mem[cpu_addr];
    end

    // video side
    // a cpu write to the same word this cycle is not seen yet
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

/* design/blank_delay.sv */
`timescale 1ns/1ps

module blank_delay #(
    parameter int blank_dly = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  colmix_pkg::sync_t sync,
    input  colmix_pkg::rgb_t  rgb_in,
    output colmix_pkg::sync_t sync_dly,
    output colmix_pkg::rgb_t  rgb
);

    // blanking shift stages, one per pixel enable
    colmix_pkg::sync_t stage_q [blank_dly];

    // colour held for one pixel
    colmix_pkg::rgb_t rgb_q;

    // visible when both blanking levels are high
    logic active;

    // reset leaves every stage blanked
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < blank_dly; i++) begin
                stage_q[i] <= '0;
            end
        end else if (pxl_cen) begin
            stage_q[0] <= sync;
            for (int i = 1; i < blank_dly; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // single colour stage
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_q <= rgb_in;
        end
    end

    assign sync_dly = stage_q[blank_dly-1];
    assign active   = sync_dly.hbl_n && sync_dly.vbl_n;

    // black while blanked
    assign rgb = active ? rgb_q : '0;

endmodule

/* design/colmix.sv */
`timescale 1ns/1ps

module colmix #(
    parameter int blank_dly = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  colmix_pkg::sync_t             sync,
    // cpu access to both palettes
    input  colmix_pkg::cpu_bus_t          cpu,
    output logic [colmix_pkg::cpu_dw-1:0] cpu_din,
    input  logic [2:0]                    prisel,
    // priority PROM load port
    input  logic [colmix_pkg::pal_aw-1:0] prom_addr,
    input  logic [1:0]                    prom_din,
    input  logic                          prom_we,
    // layer pixels
    input  colmix_pkg::layer_pxls_t       pxls,
    input  logic [3:0]                    gfx_en,
    output colmix_pkg::rgb_t              rgb,
    output colmix_pkg::sync_t             sync_dly
);

    logic [colmix_pkg::pal_aw-1:0] prio_sel_addr;
    logic [colmix_pkg::pal_aw-1:0] pal_addr;
    colmix_pkg::layer_sel_e        layer;

    // byte enables for each RAM
    logic [1:0] we_gr;
    logic       we_b;

    // cpu and video read data
    logic [15:0] cpu_gr;
    logic [15:0] vid_gr;
    logic [7:0]  cpu_b;
    logic [7:0]  vid_b;

    // cs of the previous cycle picks the read-back source
    logic cs_gr_q;

    colmix_pkg::rgb_t pal_rgb;

    assign we_gr = ~cpu.dsn & {2{cpu.cs[0]}};

    // blue is a byte RAM on the low lane
    assign we_b = ~cpu.dsn[0] & cpu.cs[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_gr_q <= 1'b0;
        end else begin
            cs_gr_q <= cpu.cs[0];
        end
    end

    // blue reads back with the high byte all ones
    assign cpu_din = cs_gr_q ? cpu_gr : {8'hff, cpu_b};

    // green on the high byte, red on the low byte
    assign pal_rgb.green = vid_gr[15:8];
    assign pal_rgb.red   = vid_gr[7:0];
    assign pal_rgb.blue  = vid_b;

    prio_addr u_prio_addr (
        .clk           (clk),
        .pxl_cen       (pxl_cen),
        .prisel        (prisel),
        .pxls          (pxls),
        .gfx_en        (gfx_en),
        .layer         (layer),
        .prio_sel_addr (prio_sel_addr),
        .pal_addr      (pal_addr)
    );

    prio_prom u_prio_prom (
        .clk     (clk),
        .rd_addr (prio_sel_addr),
        .wr_addr (prom_addr),
        .din     (prom_din),
        .we      (prom_we),
        .layer   (layer)
    );

    // red and green palette
    pal_ram #(.dw(16)) u_ram_gr (
        .clk       (clk),
        .cpu_addr  (cpu.addr),
        .cpu_wdata (cpu.wdata),
        .cpu_we    (we_gr),
        .cpu_q     (cpu_gr),
        .vid_addr  (pal_addr),
        .vid_q     (vid_gr)
    );

    // blue palette
    pal_ram #(.dw(8)) u_ram_b (
        .clk       (clk),
        .cpu_addr  (cpu.addr),
        .cpu_wdata (cpu.wdata[7:0]),
        .cpu_we    (we_b),
        .cpu_q     (cpu_b),
        .vid_addr  (pal_addr),
        .vid_q     (vid_b)
    );

    blank_delay #(.blank_dly(blank_dly)) u_blank (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .sync     (sync),
        .rgb_in   (pal_rgb),
        .sync_dly (sync_dly),
        .rgb      (rgb)
    );

endmodule

/* test/colmix_props.sv */
`timescale 1ns/1ps

module colmix_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          pxl_cen,
    input colmix_pkg::rgb_t              rgb,
    input colmix_pkg::sync_t             sync_dly,
    input logic [colmix_pkg::pal_aw-1:0] pal_addr,
    input colmix_pkg::cpu_bus_t          cpu,
    input logic [15:0]                   cpu_din
);

    // black output during either blanking
    a_black: assert property (@(posedge clk) disable iff (rst)
        !(sync_dly.hbl_n && sync_dly.vbl_n) |-> rgb == '0)
        else $error("rgb not black while blanked");

    // palette address moves only after a pixel enable
    a_pal_step: assert property (@(posedge clk) disable iff (rst)
        $changed(pal_addr) |-> $past(pxl_cen))
        else $error("pal_addr changed without pxl_cen");

    // blue read-back carries ff on top
    a_blue_hi: assert property (@(posedge clk) disable iff (rst)
        $past(!cpu.cs[0]) |-> cpu_din[15:8] == 8'hff)
        else $error("cpu_din high byte not ff on blue read");

endmodule

bind colmix colmix_props u_props (
    .clk      (clk),
    .rst      (rst),
    .pxl_cen  (pxl_cen),
    .rgb      (rgb),
    .sync_dly (sync_dly),
    .pal_addr (pal_addr),
    .cpu      (cpu),
    .cpu_din  (cpu_din)
);

/* test/colmix_tb.sv */
`timescale 1ns/1ps

module colmix_tb;

    logic                    clk;
    logic                    rst;
    logic                    pxl_cen;
    colmix_pkg::sync_t       sync;
    colmix_pkg::cpu_bus_t    cpu;
    logic [15:0]             cpu_din;
    logic [2:0]              prisel;
    logic [9:0]              prom_addr;
    logic [1:0]              prom_din;
    logic                    prom_we;
    colmix_pkg::layer_pxls_t pxls;
    logic [3:0]              gfx_en;
    colmix_pkg::rgb_t        rgb;
    colmix_pkg::sync_t       sync_dly;

    // reference models of the PROM and both palettes
    logic [1:0]  prom_m [1024];
    logic [15:0] gr_m [1024];
    logic [7:0]  b_m [1024];

    // expected results, two pixel periods deep
    colmix_pkg::rgb_t  exp_rgb_q [$];
    colmix_pkg::sync_t exp_sync_q [$];

    logic [31:0] lfsr = 32'hcae7;
    int rgb_err = 0;
    int cpu_err = 0;
    int sync_err = 0;
    int file_err = 0;

    colmix DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop if anything stalls
    initial begin
        #400000;
        $display("simulation timed out before the input file was done");
        $display("errors: rgb %0d cpu %0d sync %0d file %0d",
                 rgb_err, cpu_err, sync_err, file_err);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic wait_clks(input int n);
        int cnt;
        cnt = 0;
        while (cnt < n) begin
            @(posedge clk);
            cnt++;
        end
        #1;
    endtask

    task automatic check_rgb(input colmix_pkg::rgb_t got, input colmix_pkg::rgb_t exp,
                             input string what);
        if (got !== exp) begin
            rgb_err++;
            $display("FAIL %0t %s: rgb %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cpu(input logic [15:0] got, input logic [15:0] exp,
                             input string what);
        if (got !== exp) begin
            cpu_err++;
            $display("FAIL %0t %s: cpu_din %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input colmix_pkg::sync_t got, input colmix_pkg::sync_t exp,
                              input string what);
        if (got !== exp) begin
            sync_err++;
            $display("FAIL %0t %s: sync_dly %b expected %b", $time, what, got, exp);
        end
    endtask

    // colour from the priority and palette rules
    function automatic colmix_pkg::rgb_t model_rgb(input logic [2:0] ps, input logic [3:0] en,
                                                   input colmix_pkg::layer_pxls_t p);
        logic [9:0]       a;
        logic [1:0]       lay;
        logic [7:0]       pix;
        colmix_pkg::rgb_t c;
        a[9:7] = ps;
        a[6] = (p.ba0.idx[2:0] == 3'd0) || !en[0];
        a[5] = p.obj.idx[7];
        a[4] = (p.obj.idx[3:0] == 4'd0) || !en[3];
        a[3] = p.ba1.idx[7];
        a[2] = p.ba1.idx[3];
        a[1] = (p.ba1.idx[2:0] == 3'd0) || !en[1];
        a[0] = !p.ba2.idx[7] && ((p.ba2.idx[2:0] == 3'd0) || !en[2]);
        lay = prom_m[a];
        case (lay)
            2'd0: pix = p.ba0.idx;
            2'd1: pix = p.obj.idx;
            2'd2: pix = p.ba1.idx;
            default: pix = p.ba2.idx;
        endcase
        c.red   = gr_m[{lay, pix}][7:0];
        c.green = gr_m[{lay, pix}][15:8];
        c.blue  = b_m[{lay, pix}];
        return c;
    endfunction

    task automatic prom_write(input logic [9:0] a, input logic [1:0] d);
        prom_addr = a;
        prom_din = d;
        prom_we = 1'b1;
        prom_m[a] = d;
        wait_clks(1);
        prom_we = 1'b0;
    endtask

    task automatic cpu_write(input logic [1:0] cs, input logic [9:0] a,
                             input logic [15:0] d, input logic [1:0] dsn);
        cpu = '{cs: cs, addr: a, wdata: d, dsn: dsn};
        if (cs[0] && !dsn[0]) gr_m[a][7:0] = d[7:0];
        if (cs[0] && !dsn[1]) gr_m[a][15:8] = d[15:8];
        if (cs[1] && !dsn[0]) b_m[a] = d[7:0];
        wait_clks(1);
        cpu = '{cs: 2'b00, addr: a, wdata: 16'h0, dsn: 2'b11};
    endtask

    task automatic cpu_read(input logic [1:0] cs, input logic [9:0] a,
                            input logic [15:0] exp);
        cpu = '{cs: cs, addr: a, wdata: 16'h0, dsn: 2'b11};
        wait_clks(1);
        check_cpu(cpu_din, exp, "cpu read");
        cpu.cs = 2'b00;
    endtask

    // one pixel period of 4 clk, pxl_cen on the last one
    task automatic pixel_period(input logic [2:0] ps, input logic [3:0] en,
                                input colmix_pkg::sync_t sy, input colmix_pkg::layer_pxls_t p,
                                input colmix_pkg::rgb_t exp_c);
        // output now belongs to the period two back
        if (exp_rgb_q.size() >= 2) begin
            check_rgb(rgb, exp_rgb_q.pop_front(), "pixel");
            check_sync(sync_dly, exp_sync_q.pop_front(), "pixel");
        end
        exp_rgb_q.push_back(exp_c);
        exp_sync_q.push_back(sy);
        prisel = ps;
        gfx_en = en;
        sync = sy;
        pxls = p;
        wait_clks(3);
        pxl_cen = 1'b1;
        wait_clks(1);
        pxl_cen = 1'b0;
    endtask

    // palette data from the lfsr, PROM from a fold of the whole address
    task automatic fill_all();
        logic [31:0] v;
        logic [9:0]  a;
        for (int i = 0; i < 1024; i++) begin
            a = 10'(i);
            prom_write(a, a[1:0] ^ a[3:2] ^ a[5:4] ^ a[7:6] ^ a[9:8]);
        end
        for (int i = 0; i < 1024; i++) begin
            take_bits(16, v);
            cpu_write(2'b01, 10'(i), v[15:0], 2'b00);
            take_bits(8, v);
            cpu_write(2'b10, 10'(i), {8'h00, v[7:0]}, 2'b00);
        end
    endtask

    initial begin
        int                      fd;
        int                      n;
        int                      cnt;
        string                   tok;
        string                   line;
        logic [1:0]              cs;
        logic [9:0]              a;
        logic [15:0]             d;
        logic [1:0]              dsn;
        logic [2:0]              ps;
        logic [3:0]              en;
        logic [1:0]              sy;
        logic [7:0]              p0;
        logic [7:0]              p1;
        logic [7:0]              p2;
        logic [7:0]              p3;
        logic [23:0]             c;
        logic [31:0]             v;
        colmix_pkg::layer_pxls_t p;

        rst = 1'b1;
        pxl_cen = 1'b0;
        sync = '0;
        cpu = '{cs: 2'b00, addr: 10'h0, wdata: 16'h0, dsn: 2'b11};
        prisel = '0;
        prom_addr = '0;
        prom_din = '0;
        prom_we = 1'b0;
        pxls = '0;
        gfx_en = '0;

        wait_clks(16);
        rst = 1'b0;
        wait_clks(1);
        check_rgb(rgb, '0, "after reset");
        check_sync(sync_dly, '0, "after reset");

        fd = $fopen("test/colmix_input.txt", "r");
        if (fd == 0) begin
            file_err++;
            $display("could not open test/colmix_input.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    n = $fgets(line, fd);
                end else if (tok == "F") begin
                    fill_all();
                end else if (tok == "P") begin
                    n = $fscanf(fd, "%h %h", a, dsn);
                    prom_write(a, dsn);
                end else if (tok == "W") begin
                    n = $fscanf(fd, "%h %h %h %h", cs, a, d, dsn);
                    cpu_write(cs, a, d, dsn);
                end else if (tok == "R") begin
                    n = $fscanf(fd, "%h %h %h", cs, a, d);
                    cpu_read(cs, a, d);
                end else if (tok == "V") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                ps, en, sy, p0, p1, p2, p3, c);
                    p = {p0, p1, p2, p3};
                    pixel_period(ps, en, sy, p, c);
                end else if (tok == "L") begin
                    n = $fscanf(fd, "%d %h %h", cnt, ps, en);
                    for (int i = 0; i < cnt; i++) begin
                        take_bits(32, v);
                        p = v;
                        pixel_period(ps, en, 2'b11, p, model_rgb(ps, en, p));
                    end
                end else begin
                    file_err++;
                    $display("unknown record %s in the input file", tok);
                end
            end
            $fclose(fd);
        end

        // drain the last two periods with blanking
        pixel_period(3'd0, 4'h0, 2'b00, '0, '0);
        pixel_period(3'd0, 4'h0, 2'b00, '0, '0);

        $display("errors: rgb %0d cpu %0d sync %0d file %0d",
                 rgb_err, cpu_err, sync_err, file_err);
        if (rgb_err + cpu_err + sync_err + file_err == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* colmix.f */
design/colmix_pkg.sv
design/prio_addr.sv
design/prio_prom.sv
design/pal_ram.sv
design/blank_delay.sv
design/colmix.sv
test/colmix_props.sv
test/colmix_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the colmix testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --top-module colmix_tb \
    -f colmix.f

./obj_dir/Vcolmix_tb | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* test/colmix_input.txt */
# F fill prom and palettes | P addr layer | W cs addr wdata dsn | R cs addr expected
# V prisel gfx_en sync ba0 obj ba1 ba2 rgb | L count prisel gfx_en (lfsr pixels)
F
P 013 0
P 053 3
P 293 2
W 1 011 a55a 0
W 1 011 ff33 2
R 1 011 a533
W 1 011 c300 1
R 1 011 c333
W 2 011 0077 0
W 2 011 0088 1
R 2 011 ff77
W 1 300 1234 0
W 2 300 0056 0
W 1 200 beef 0
W 2 200 0001 0
R 1 300 1234
R 2 200 ff01
V 0 f 3 11 00 00 00 33c377
V 0 e 3 11 00 00 00 341256
V 5 f 3 11 00 00 00 efbe01
V 0 f 1 11 00 00 00 000000
V 0 f 2 11 00 00 00 000000
V 0 f 3 11 00 00 00 33c377
L 24 0 f
L 24 5 b
L 24 2 f
L 24 7 6
